// File: include/accel_defs.svh
`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// signed pixel, weight and output word
`define ACCEL_WORD_WIDTH 8

// signed accumulator lane, room for taps of 8x8 products
`define ACCEL_ACC_WIDTH 24

// parallel pixel lanes per beat
`define ACCEL_UNITS 4

// taps summed per output window
`define ACCEL_KERNEL_TAPS 3

// leak factor for negative sums, 2**-3
`define ACCEL_LRELU_SHIFT 3

// requantize shift ahead of the clamp
`define ACCEL_OUT_SHIFT 2

`endif

// File: hdl/accel_pkg.sv
`include "accel_defs.svh"

package accel_pkg;

  // one signed word, elements of a pixel vector
  typedef logic signed [`ACCEL_WORD_WIDTH-1:0] word_t;

  // one signed accumulator lane
  typedef logic signed [`ACCEL_ACC_WIDTH-1:0] acc_t;

  // lane 0 sits in the low bits
  typedef word_t [`ACCEL_UNITS-1:0] pixel_vec_t;
  typedef acc_t [`ACCEL_UNITS-1:0] acc_vec_t;

  // beat on the pixel slave port
  typedef struct packed {
    pixel_vec_t pixels;
    logic       last;
  } pix_beat_t;

  // joined pixel and weight beat, input pipe to conv engine
  typedef struct packed {
    pixel_vec_t pixels;
    word_t      weight;
    logic       last;
  } conv_beat_t;

  // window sums, conv engine to lrelu engine
  typedef struct packed {
    acc_vec_t data;
    logic     last;
  } acc_beat_t;

  // requantized results on the master port
  typedef struct packed {
    pixel_vec_t data;
    logic       last;
  } out_beat_t;

  // conv controller states
  // ACCUM is the reset state
  typedef enum logic {
    ACCUM = 1'b0,
    HOLD  = 1'b1
  } conv_state_e;

endpackage

// File: hdl/axis_input_pipe.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module axis_input_pipe (
  input  logic                                aclk,
  input  logic                                rst_n,
  input  accel_pkg::pix_beat_t                s_axis_pixels,
  input  logic                                s_axis_pixels_tvalid,
  output logic                                s_axis_pixels_tready,
  input  logic signed [`ACCEL_WORD_WIDTH-1:0] s_axis_weights,
  input  logic                                s_axis_weights_tvalid,
  output logic                                s_axis_weights_tready,
  output accel_pkg::conv_beat_t               m_axis,
  output logic                                m_axis_tvalid,
  input  logic                                m_axis_tready
);

  // one-entry output register
  accel_pkg::conv_beat_t beat_q;
  logic                  valid_q;

  // register can take a new beat
  logic                  slot_free;
  // both streams transfer on this edge
  logic                  join_take;

  // empty, or its beat leaves on this edge
  assign slot_free = !valid_q || m_axis_tready;

  // each side is ready only when the other side has data too,
  // so one stream never moves without the other
  assign s_axis_pixels_tready  = s_axis_weights_tvalid && slot_free;
  assign s_axis_weights_tready = s_axis_pixels_tvalid && slot_free;

  assign join_take = s_axis_pixels_tvalid && s_axis_weights_tvalid && slot_free;

  // valid flag
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (join_take) begin
      valid_q <= 1'b1;
    end else if (m_axis_tready) begin
      // drained with nothing behind it
      valid_q <= 1'b0;
    end
  end

  // payload, held while stalled
  always_ff @(posedge aclk) begin
    if (join_take) begin
      beat_q.pixels <= s_axis_pixels.pixels;
      beat_q.weight <= s_axis_weights;
      // window boundary rides on the pixel stream
      beat_q.last   <= s_axis_pixels.last;
    end
  end

  assign m_axis        = beat_q;
  assign m_axis_tvalid = valid_q;

endmodule

// File: hdl/conv_tap_counter.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module conv_tap_counter (
  input  logic aclk,
  input  logic rst_n,
  input  logic tap_accept,
  output logic window_done
);

  // wide enough to hold KERNEL_TAPS-1
  localparam int CNT_W = $clog2(`ACCEL_KERNEL_TAPS + 1);
  localparam logic [CNT_W-1:0] LAST_TAP = CNT_W'(`ACCEL_KERNEL_TAPS - 1);

  // taps accepted so far in this window
  logic [CNT_W-1:0] count_q;

  // the next accepted tap closes the window
  assign window_done = (count_q == LAST_TAP);

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (tap_accept) begin
      // wrap back to zero after the closing tap
      if (window_done) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

// File: hdl/conv_ctrl_fsm.sv
`timescale 1ns/1ps

module conv_ctrl_fsm (
  input  logic                   aclk,
  input  logic                   rst_n,
  input  logic                   tap_accept,
  input  logic                   window_done,
  input  logic                   result_taken,
  output accel_pkg::conv_state_e state,
  output logic                   acc_clear
);

  accel_pkg::conv_state_e state_q;
  accel_pkg::conv_state_e state_d;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      accel_pkg::ACCUM: begin
        // closing tap of the window accepted
        if (tap_accept && window_done) begin
          state_d = accel_pkg::HOLD;
        end
      end
      accel_pkg::HOLD: begin
        // sums leave, start the next window
        if (result_taken) begin
          state_d = accel_pkg::ACCUM;
        end
      end
      default: begin
        state_d = accel_pkg::ACCUM;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state_q <= accel_pkg::ACCUM;
    end else begin
      state_q <= state_d;
    end
  end

  // single cycle, on the handshake that empties HOLD
  assign acc_clear = (state_q == accel_pkg::HOLD) && result_taken;

  assign state = state_q;

endmodule

// File: hdl/axis_conv_engine.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module axis_conv_engine (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  accel_pkg::conv_beat_t s_axis,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  output accel_pkg::acc_beat_t  m_axis,
  output logic                  m_axis_tvalid,
  input  logic                  m_axis_tready
);

  localparam int PROD_W = 2 * `ACCEL_WORD_WIDTH;

  accel_pkg::conv_state_e state;

  logic tap_accept;
  logic window_done;
  logic result_taken;
  logic acc_clear;

  // per-lane pixel x weight
  logic signed [PROD_W-1:0] prod [`ACCEL_UNITS];

  // running sums plus the window's last flag
  accel_pkg::acc_beat_t acc_q;

  // taps only while accumulating, results only while holding
  assign s_axis_tready = (state == accel_pkg::ACCUM);
  assign m_axis_tvalid = (state == accel_pkg::HOLD);

  assign tap_accept   = s_axis_tvalid && s_axis_tready;
  assign result_taken = m_axis_tvalid && m_axis_tready;

  conv_tap_counter tap_counter (
    .aclk        (aclk       ),
    .rst_n       (rst_n      ),
    .tap_accept  (tap_accept ),
    .window_done (window_done)
  );

  conv_ctrl_fsm ctrl_fsm (
    .aclk         (aclk        ),
    .rst_n        (rst_n       ),
    .tap_accept   (tap_accept  ),
    .window_done  (window_done ),
    .result_taken (result_taken),
    .state        (state       ),
    .acc_clear    (acc_clear   )
  );

  // full-width signed 8x8 products
  always_comb begin
    for (int i = 0; i < `ACCEL_UNITS; i++) begin
      prod[i] = s_axis.pixels[i] * s_axis.weight;
    end
  end

  // sums and window flag clear on reset and on hand-off
  always_ff @(posedge aclk) begin
    if (!rst_n || acc_clear) begin
      acc_q <= '0;
    end else if (tap_accept) begin
      for (int i = 0; i < `ACCEL_UNITS; i++) begin
        // product sign-extends into the lane
        acc_q.data[i] <= acc_q.data[i] + prod[i];
      end
      // flag of the closing tap marks the window
      if (window_done) begin
        acc_q.last <= s_axis.last;
      end
    end
  end

  assign m_axis = acc_q;

endmodule

// File: hdl/axis_lrelu_engine.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module axis_lrelu_engine (
  input  logic                 aclk,
  input  logic                 rst_n,
  input  accel_pkg::acc_beat_t s_axis,
  input  logic                 s_axis_tvalid,
  output logic                 s_axis_tready,
  output accel_pkg::out_beat_t m_axis,
  output logic                 m_axis_tvalid,
  input  logic                 m_axis_tready
);

  // signed word range, held at accumulator width for the compare
  localparam accel_pkg::acc_t WORD_MAX = (1 <<< (`ACCEL_WORD_WIDTH - 1)) - 1;
  localparam accel_pkg::acc_t WORD_MIN = -(1 <<< (`ACCEL_WORD_WIDTH - 1));

  // output stage
  accel_pkg::out_beat_t out_q;
  logic                 valid_q;

  // next results, per lane
  accel_pkg::pixel_vec_t lane_res;
  logic                  stage_take;

  // empty, or emptied on this edge
  assign s_axis_tready = !valid_q || m_axis_tready;
  assign stage_take    = s_axis_tvalid && s_axis_tready;

  always_comb begin
    accel_pkg::acc_t leaked;
    accel_pkg::acc_t scaled;
    for (int i = 0; i < `ACCEL_UNITS; i++) begin
      // negative sums leak, positive pass
      if (s_axis.data[i] < 0) begin
        leaked = s_axis.data[i] >>> `ACCEL_LRELU_SHIFT;
      end else begin
        leaked = s_axis.data[i];
      end
      // requantize, then clamp to the word
      scaled = leaked >>> `ACCEL_OUT_SHIFT;
      if (scaled > WORD_MAX) begin
        lane_res[i] = WORD_MAX[`ACCEL_WORD_WIDTH-1:0];
      end else if (scaled < WORD_MIN) begin
        lane_res[i] = WORD_MIN[`ACCEL_WORD_WIDTH-1:0];
      end else begin
        lane_res[i] = scaled[`ACCEL_WORD_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (stage_take) begin
      valid_q <= 1'b1;
    end else if (m_axis_tready) begin
      valid_q <= 1'b0;
    end
  end

  // result payload, no reset
  always_ff @(posedge aclk) begin
    if (stage_take) begin
      out_q.data <= lane_res;
      out_q.last <= s_axis.last;
    end
  end

  assign m_axis        = out_q;
  assign m_axis_tvalid = valid_q;

endmodule

// File: hdl/axis_accelerator.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module axis_accelerator (
  input  logic                                aclk,
  input  logic                                rst_n,
  input  accel_pkg::pix_beat_t                s_axis_pixels,
  input  logic                                s_axis_pixels_tvalid,
  output logic                                s_axis_pixels_tready,
  input  logic signed [`ACCEL_WORD_WIDTH-1:0] s_axis_weights,
  input  logic                                s_axis_weights_tvalid,
  output logic                                s_axis_weights_tready,
  output accel_pkg::out_beat_t                m_axis,
  output logic                                m_axis_tvalid,
  input  logic                                m_axis_tready
);

  // input pipe to conv engine
  accel_pkg::conv_beat_t input_m_axis;
  logic                  input_m_axis_tvalid;
  logic                  input_m_axis_tready;

  // conv engine to lrelu engine
  accel_pkg::acc_beat_t  conv_m_axis;
  logic                  conv_m_axis_tvalid;
  logic                  conv_m_axis_tready;

  // pixels and weight joined into one beat
  axis_input_pipe input_pipe (
    .aclk                  (aclk                 ),
    .rst_n                 (rst_n                ),
    .s_axis_pixels         (s_axis_pixels        ),
    .s_axis_pixels_tvalid  (s_axis_pixels_tvalid ),
    .s_axis_pixels_tready  (s_axis_pixels_tready ),
    .s_axis_weights        (s_axis_weights       ),
    .s_axis_weights_tvalid (s_axis_weights_tvalid),
    .s_axis_weights_tready (s_axis_weights_tready),
    .m_axis                (input_m_axis         ),
    .m_axis_tvalid         (input_m_axis_tvalid  ),
    .m_axis_tready         (input_m_axis_tready  )
  );

  // window sums per lane
  axis_conv_engine CONV_ENGINE (
    .aclk          (aclk               ),
    .rst_n         (rst_n              ),
    .s_axis        (input_m_axis       ),
    .s_axis_tvalid (input_m_axis_tvalid),
    .s_axis_tready (input_m_axis_tready),
    .m_axis        (conv_m_axis        ),
    .m_axis_tvalid (conv_m_axis_tvalid ),
    .m_axis_tready (conv_m_axis_tready )
  );

  // leak, requantize, saturate
  axis_lrelu_engine LRELU_ENGINE (
    .aclk          (aclk              ),
    .rst_n         (rst_n             ),
    .s_axis        (conv_m_axis       ),
    .s_axis_tvalid (conv_m_axis_tvalid),
    .s_axis_tready (conv_m_axis_tready),
    .m_axis        (m_axis            ),
    .m_axis_tvalid (m_axis_tvalid     ),
    .m_axis_tready (m_axis_tready     )
  );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic aclk
);

  // free running, starts low
  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

endmodule

// File: verif/accel_assertions.sv
`timescale 1ns/1ps

module accel_assertions (
  input logic                 aclk,
  input logic                 rst_n,
  input accel_pkg::pix_beat_t s_axis_pixels,
  input logic                 s_axis_pixels_tvalid,
  input logic                 s_axis_pixels_tready,
  input accel_pkg::word_t     s_axis_weights,
  input logic                 s_axis_weights_tvalid,
  input logic                 s_axis_weights_tready,
  input accel_pkg::out_beat_t m_axis,
  input logic                 m_axis_tvalid,
  input logic                 m_axis_tready
);

  // stalled output beat keeps valid and payload
  out_stall_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis))
    else $error("m_axis changed while stalled");

  // same rule on the pixel slave port
  pix_stall_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    s_axis_pixels_tvalid && !s_axis_pixels_tready |=>
    s_axis_pixels_tvalid && $stable(s_axis_pixels))
    else $error("s_axis_pixels changed while stalled");

  // and on the weight slave port
  wgt_stall_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    s_axis_weights_tvalid && !s_axis_weights_tready |=>
    s_axis_weights_tvalid && $stable(s_axis_weights))
    else $error("s_axis_weights changed while stalled");

  // treadys stay low in reset
  rst_ready_low: assert property (@(posedge aclk)
    !rst_n |-> !s_axis_pixels_tready && !s_axis_weights_tready)
    else $error("tready high during reset");

  // output valid cleared once reset has been seen for a cycle
  rst_valid_low: assert property (@(posedge aclk)
    !rst_n && $past(!rst_n) |-> !m_axis_tvalid)
    else $error("m_axis_tvalid high during reset");

endmodule

bind axis_accelerator accel_assertions handshake_checks (.*);

// File: verif/tb_accelerator.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module tb_accelerator;

  localparam int TAPS        = `ACCEL_KERNEL_TAPS;
  localparam int NUM_ROWS    = 10;
  localparam int CLK_NS      = 4;
  localparam int WATCHDOG_NS = NUM_ROWS * TAPS * 20 * CLK_NS;
  localparam int WORD_MAX    = (1 << (`ACCEL_WORD_WIDTH - 1)) - 1;
  localparam int WORD_MIN    = -(1 << (`ACCEL_WORD_WIDTH - 1));

  // one window: pixels and weight per tap, last on the closing tap
  typedef struct packed {
    accel_pkg::pixel_vec_t [TAPS-1:0] pix;
    accel_pkg::word_t [TAPS-1:0]      wgt;
    logic                             last;
  } row_t;

  logic                  aclk;
  logic                  rst_n;
  accel_pkg::pix_beat_t  s_axis_pixels;
  logic                  s_axis_pixels_tvalid;
  logic                  s_axis_pixels_tready;
  accel_pkg::word_t      s_axis_weights;
  logic                  s_axis_weights_tvalid;
  logic                  s_axis_weights_tready;
  accel_pkg::out_beat_t  m_axis;
  logic                  m_axis_tvalid;
  logic                  m_axis_tready;

  row_t                  rows [NUM_ROWS];
  accel_pkg::out_beat_t  expected_q [$];
  int                    errors = 0;
  int                    n_rx = 0;

  tb_clk_gen #(.PERIOD_NS(CLK_NS)) clk_gen (.aclk(aclk));

  axis_accelerator DUT (
    .aclk                  (aclk                 ),
    .rst_n                 (rst_n                ),
    .s_axis_pixels         (s_axis_pixels        ),
    .s_axis_pixels_tvalid  (s_axis_pixels_tvalid ),
    .s_axis_pixels_tready  (s_axis_pixels_tready ),
    .s_axis_weights        (s_axis_weights       ),
    .s_axis_weights_tvalid (s_axis_weights_tvalid),
    .s_axis_weights_tready (s_axis_weights_tready),
    .m_axis                (m_axis               ),
    .m_axis_tvalid         (m_axis_tvalid        ),
    .m_axis_tready         (m_axis_tready        )
  );

  // random rows first, then the directed ones on top
  task automatic fill_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int t = 0; t < TAPS; t++) begin
        rows[r].wgt[t] = accel_pkg::word_t'($urandom);
        for (int l = 0; l < `ACCEL_UNITS; l++) begin
          rows[r].pix[t][l] = accel_pkg::word_t'($urandom);
        end
      end
      rows[r].last = 1'($urandom % 2);
    end
    for (int t = 0; t < TAPS; t++) begin
      rows[0].wgt[t] = 8'sd2;
      rows[1].wgt[t] = 8'sd3;
      rows[2].wgt[t] = 8'sd127;
      for (int l = 0; l < `ACCEL_UNITS; l++) begin
        // positive pass-through
        rows[0].pix[t][l] = accel_pkg::word_t'(10 * (l + 1));
        // negative, leaked
        rows[1].pix[t][l] = accel_pkg::word_t'(-25 * (l + 1));
        // saturation both ways, alternating lanes
        rows[2].pix[t][l] = (l % 2 == 0) ? 8'sd127 : -8'sd128;
      end
    end
    rows[0].last = 1'b0;
    rows[1].last = 1'b1;
    rows[2].last = 1'b0;
  endtask

  // expected beat from the window sum, leak, shift and clamp rules
  function automatic accel_pkg::out_beat_t ref_window(row_t r);
    accel_pkg::out_beat_t res;
    int                   sum;
    for (int l = 0; l < `ACCEL_UNITS; l++) begin
      sum = 0;
      for (int t = 0; t < TAPS; t++) begin
        sum += int'($signed(r.pix[t][l])) * int'($signed(r.wgt[t]));
      end
      if (sum < 0) begin
        sum = sum >>> `ACCEL_LRELU_SHIFT;
      end
      sum = sum >>> `ACCEL_OUT_SHIFT;
      if (sum > WORD_MAX) begin
        sum = WORD_MAX;
      end else if (sum < WORD_MIN) begin
        sum = WORD_MIN;
      end
      res.data[l] = accel_pkg::word_t'(sum);
    end
    res.last = r.last;
    return res;
  endfunction

  task automatic check_words(string name, accel_pkg::pixel_vec_t exp,
                             accel_pkg::pixel_vec_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_last(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // starts and ends on a falling edge; both streams move together
  task automatic send_tap(accel_pkg::pixel_vec_t pix, accel_pkg::word_t w, logic last);
    logic taken;
    // random idle gap
    while ($urandom % 4 == 0) begin
      @(negedge aclk);
    end
    s_axis_pixels.pixels  = pix;
    s_axis_pixels.last    = last;
    s_axis_weights        = w;
    s_axis_pixels_tvalid  = 1'b1;
    s_axis_weights_tvalid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      // mid-cycle, ready settled before the rising edge
      #1;
      taken = s_axis_pixels_tready && s_axis_weights_tready;
      @(negedge aclk);
    end
    s_axis_pixels_tvalid  = 1'b0;
    s_axis_weights_tvalid = 1'b0;
  endtask

  task automatic send_rows();
    for (int r = 0; r < NUM_ROWS; r++) begin
      expected_q.push_back(ref_window(rows[r]));
      for (int t = 0; t < TAPS; t++) begin
        send_tap(rows[r].pix[t], rows[r].wgt[t], rows[r].last && (t == TAPS - 1));
      end
    end
  endtask

  // random back-pressure, in-order compare
  task automatic collect_outputs();
    accel_pkg::out_beat_t exp;
    int                   row_errors;
    while (n_rx < NUM_ROWS) begin
      @(negedge aclk);
      m_axis_tready = ($urandom % 4) != 0;
      #1;
      if (m_axis_tvalid && m_axis_tready) begin
        if (expected_q.size() == 0) begin
          $display("output beat at %0t arrived with no window pending", $time);
          errors++;
        end else begin
          exp = expected_q.pop_front();
          row_errors = errors;
          check_words("m_axis.data", exp.data, m_axis.data);
          check_last("m_axis.last", exp.last, m_axis.last);
          $display("row %0d %s", n_rx, (errors == row_errors) ? "ok" : "mismatch");
        end
        n_rx++;
      end
    end
  endtask

  initial begin
    void'($urandom(11));
    rst_n                 = 1'b0;
    s_axis_pixels         = '0;
    s_axis_pixels_tvalid  = 1'b0;
    s_axis_weights        = '0;
    s_axis_weights_tvalid = 1'b0;
    m_axis_tready         = 1'b0;
    fill_table();
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;
    fork
      send_rows();
      collect_outputs();
    join
    // sink always ready, nothing more may come out
    @(negedge aclk);
    m_axis_tready = 1'b1;
    repeat (8) begin
      @(negedge aclk);
      #1;
      if (m_axis_tvalid) begin
        $display("extra output beat at %0t after all windows", $time);
        errors++;
      end
    end
    $display("rows %0d received %0d errors %0d", NUM_ROWS, n_rx, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // generous bound per tap, stalls included
  initial begin
    #(WATCHDOG_NS);
    $display("timeout, %0d of %0d outputs went missing", NUM_ROWS - n_rx, NUM_ROWS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: all.f
+incdir+include
hdl/accel_pkg.sv
hdl/axis_input_pipe.sv
hdl/conv_tap_counter.sv
hdl/conv_ctrl_fsm.sv
hdl/axis_conv_engine.sv
hdl/axis_lrelu_engine.sv
hdl/axis_accelerator.sv
verif/tb_clk_gen.sv
verif/accel_assertions.sv
verif/tb_accelerator.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_accelerator

output=$(./obj_dir/Vtb_accelerator)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
  exit 0
else
  exit 1
fi
